// ==== rtl/alu_execute.sv ====
`include "rv_alu_settings.svh"

module alu_execute import rv_alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      dec_valid_i,
    input  alu_op_t   dec_op_i,
    input  word_t     dec_a_i,
    input  word_t     dec_b_i,
    input  reg_addr_t dec_rd_i,

    output logic      ex_valid_o,
    output reg_addr_t ex_rd_o,
    output word_t     ex_data_o
);

    logic [4:0] shamt;
    word_t      alu_res;
    logic       writes;

    assign shamt = dec_b_i[4:0];

    always_comb begin
        case (dec_op_i)
            OP_ADD:  alu_res = dec_a_i + dec_b_i;
            OP_SUB:  alu_res = dec_a_i - dec_b_i;
            OP_SLL:  alu_res = dec_a_i << shamt;
            OP_SLT: begin
                alu_res = {{(`XLEN-1){1'b0}}, $signed(dec_a_i) < $signed(dec_b_i)};
            end
            OP_SLTU: begin
                alu_res = {{(`XLEN-1){1'b0}}, dec_a_i < dec_b_i};
            end
            OP_XOR:  alu_res = dec_a_i ^ dec_b_i;
            OP_SRL:  alu_res = dec_a_i >> shamt;
            OP_SRA:  alu_res = word_t'($signed(dec_a_i) >>> shamt);   // keep sign
            OP_OR:   alu_res = dec_a_i | dec_b_i;
            OP_AND:  alu_res = dec_a_i & dec_b_i;
            default: alu_res = '0;
        endcase
    end

    // nop and x0 writes die here
    assign writes = dec_valid_i && (dec_op_i != OP_NOP) && (dec_rd_i != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
            ex_rd_o    <= '0;
            ex_data_o  <= '0;
        end else begin
            ex_valid_o <= writes;
            if (writes) begin
                ex_rd_o   <= dec_rd_i;
                ex_data_o <= alu_res;
            end
        end
    end

endmodule

// ==== rtl/inst_decode.sv ====
`include "rv_alu_settings.svh"

module inst_decode import rv_alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  inst_t     wb_dat_i,
    output logic      wb_ack_o,

    output reg_addr_t rf_raddr1_o,
    output reg_addr_t rf_raddr2_o,
    input  word_t     rf_rdata1_i,
    input  word_t     rf_rdata2_i,

    input  logic      byp_we_i,
    input  reg_addr_t byp_addr_i,
    input  word_t     byp_data_i,

    output logic      dec_valid_o,
    output alu_op_t   dec_op_o,
    output word_t     dec_a_o,
    output word_t     dec_b_o,
    output reg_addr_t dec_rd_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;

    logic       accept;
    alu_op_t    op;
    logic       use_imm;
    logic       is_shift;
    word_t      imm_i;
    word_t      shamt;
    word_t      rs1_val;
    word_t      rs2_val;

    assign opcode = wb_dat_i[6:0];
    assign funct3 = wb_dat_i[14:12];
    assign funct7 = wb_dat_i[31:25];
    assign rd     = wb_dat_i[11:7];
    assign rs1    = wb_dat_i[19:15];
    assign rs2    = wb_dat_i[24:20];

    assign imm_i  = {{(`XLEN-12){wb_dat_i[31]}}, wb_dat_i[31:20]};
    assign shamt  = {{(`XLEN-5){1'b0}}, wb_dat_i[24:20]};

    // new request only while ack is low
    assign accept = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_comb begin
        op       = OP_NOP;
        use_imm  = 1'b0;
        is_shift = 1'b0;
        case (opcode)
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                case (funct3)
                    `F3_ADD:  op = OP_ADD;
                    `F3_SLT:  op = OP_SLT;
                    `F3_SLTU: op = OP_SLTU;
                    `F3_XOR:  op = OP_XOR;
                    `F3_OR:   op = OP_OR;
                    `F3_AND:  op = OP_AND;
                    `F3_SLL: begin
                        is_shift = 1'b1;
                        op       = OP_SLL;
                    end
                    `F3_SR: begin
                        is_shift = 1'b1;
                        op       = wb_dat_i[30] ? OP_SRA : OP_SRL;   // srai vs srli
                    end
                    default: op = OP_NOP;
                endcase
            end
            `OPC_OP: begin
                case (funct3)
                    `F3_ADD: begin
                        if (funct7 == `F7_BASE) op = OP_ADD;
                        else if (funct7 == `F7_ALT) op = OP_SUB;
                    end
                    `F3_SR: begin
                        if (funct7 == `F7_BASE) op = OP_SRL;
                        else if (funct7 == `F7_ALT) op = OP_SRA;
                    end
                    `F3_SLL:  if (funct7 == `F7_BASE) op = OP_SLL;
                    `F3_SLT:  if (funct7 == `F7_BASE) op = OP_SLT;
                    `F3_SLTU: if (funct7 == `F7_BASE) op = OP_SLTU;
                    `F3_XOR:  if (funct7 == `F7_BASE) op = OP_XOR;
                    `F3_OR:   if (funct7 == `F7_BASE) op = OP_OR;
                    `F3_AND:  if (funct7 == `F7_BASE) op = OP_AND;
                    default:  op = OP_NOP;
                endcase
            end
            default: op = OP_NOP;   // loads, stores, branches, lui, auipc
        endcase
    end

    assign rf_raddr1_o = rs1;
    assign rf_raddr2_o = rs2;

    // result stage writes on the same edge as this accept
    assign rs1_val = (byp_we_i && byp_addr_i == rs1) ? byp_data_i : rf_rdata1_i;
    assign rs2_val = (byp_we_i && byp_addr_i == rs2) ? byp_data_i : rf_rdata2_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_ack_o    <= 1'b0;
            dec_valid_o <= 1'b0;
            dec_op_o    <= OP_NOP;
            dec_a_o     <= '0;
            dec_b_o     <= '0;
            dec_rd_o    <= '0;
        end else begin
            wb_ack_o    <= accept;   // one cycle pulse
            dec_valid_o <= accept && wb_we_i;   // reads are acked and dropped
            if (accept && wb_we_i) begin
                dec_op_o <= op;
                dec_a_o  <= rs1_val;
                if (use_imm) begin
                    dec_b_o <= is_shift ? shamt : imm_i;
                end else begin
                    dec_b_o <= rs2_val;
                end
                dec_rd_o <= (op == OP_NOP) ? '0 : rd;
            end
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`include "rv_alu_settings.svh"

module reg_file (
    input  logic                   clk,

    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o,

    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`XLEN-1:0]       wdata_i
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin   // x0 stays untouched
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads as zero
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

endmodule

// ==== rtl/result_stage.sv ====
module result_stage import rv_alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      ex_valid_i,
    input  reg_addr_t ex_rd_i,
    input  word_t     ex_data_i,

    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output word_t     rf_wdata_o,

    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o
);

    logic      ret_valid;
    reg_addr_t ret_rd;
    word_t     ret_data;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ret_valid <= 1'b0;
            ret_rd    <= '0;
            ret_data  <= '0;
        end else begin
            ret_valid <= ex_valid_i;
            if (ex_valid_i) begin
                ret_rd   <= ex_rd_i;
                ret_data <= ex_data_i;
            end
        end
    end

    // write lands at the end of the retire cycle, also feeds decode bypass
    assign rf_we_o    = ret_valid;
    assign rf_waddr_o = ret_rd;
    assign rf_wdata_o = ret_data;

    assign retire_valid_o = ret_valid;
    assign retire_rd_o    = ret_rd;
    assign retire_data_o  = ret_data;

endmodule

// ==== rtl/rv_alu_pkg.sv ====
`include "rv_alu_settings.svh"

package rv_alu_pkg;

    // one data word
    typedef logic [`XLEN-1:0] word_t;

    // register index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // raw instruction word
    typedef logic [31:0] inst_t;

    // operation passed from decode to execute
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_SLL  = 4'd3,
        OP_SLT  = 4'd4,
        OP_SLTU = 4'd5,
        OP_XOR  = 4'd6,
        OP_SRL  = 4'd7,
        OP_SRA  = 4'd8,
        OP_OR   = 4'd9,
        OP_AND  = 4'd10
    } alu_op_t;

endpackage

// ==== rtl/rv_alu_settings.svh ====
`ifndef RV_ALU_SETTINGS_SVH
`define RV_ALU_SETTINGS_SVH

// datapath and register file geometry
`define XLEN        32
`define REG_ADDR_W  5
`define REG_COUNT   32

// major opcodes kept by the core
`define OPC_OP_IMM  7'b0010011   // register-immediate group
`define OPC_OP      7'b0110011   // register-register group

// funct3 codes shared by both groups
`define F3_ADD      3'b000   // add, sub, addi
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101   // srl, sra and immediate forms
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 codes
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000   // selects sub and sra

`endif

// ==== rtl/rv_alu_top.sv ====
module rv_alu_top import rv_alu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,

    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  inst_t     wb_dat_i,
    output logic      wb_ack_o,

    output logic      retire_valid_o,
    output reg_addr_t retire_rd_o,
    output word_t     retire_data_o
);

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;

    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    logic      dec_valid;
    alu_op_t   dec_op;
    word_t     dec_a;
    word_t     dec_b;
    reg_addr_t dec_rd;

    logic      ex_valid;
    reg_addr_t ex_rd;
    word_t     ex_data;

    inst_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .byp_we_i    (rf_we),      // bypass taps the write port
        .byp_addr_i  (rf_waddr),
        .byp_data_i  (rf_wdata),
        .dec_valid_o (dec_valid),
        .dec_op_o    (dec_op),
        .dec_a_o     (dec_a),
        .dec_b_o     (dec_b),
        .dec_rd_o    (dec_rd)
    );

    alu_execute u_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_valid_i (dec_valid),
        .dec_op_i    (dec_op),
        .dec_a_i     (dec_a),
        .dec_b_i     (dec_b),
        .dec_rd_i    (dec_rd),
        .ex_valid_o  (ex_valid),
        .ex_rd_o     (ex_rd),
        .ex_data_o   (ex_data)
    );

    result_stage u_result (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ex_valid_i     (ex_valid),
        .ex_rd_i        (ex_rd),
        .ex_data_i      (ex_data),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    reg_file u_regs (
        .clk      (clk),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the rv_alu testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_rv_alu

verilator --binary --timing -f sim.f --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
    if [ $run_status -ne 0 ]; then
        exit 1
    fi
    exit 0
fi

echo "pass line not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+rtl
rtl/rv_alu_pkg.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/alu_execute.sv
rtl/result_stage.sv
rtl/rv_alu_top.sv
verif/tb_rv_alu.sv

// ==== verif/tb_rv_alu.sv ====
module tb_rv_alu import rv_alu_pkg::*;;

    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;

    localparam int N_IMM   = 60;
    localparam int N_REG   = 60;
    localparam int N_CHAIN = 20;
    localparam int N_GAP   = 40;
    localparam int N_ISSUED = 31 + 3 + N_IMM + 2 + N_REG + N_CHAIN + 8 + N_GAP;
    localparam int WATCHDOG_CYCLES = N_ISSUED * 8 + 200;
    localparam logic [31:0] ACK_TO_RETIRE = 32'd2;   // retire cycle starts two edges after ack edge

    typedef word_t reg_arr_t [32];

    typedef struct packed {
        logic [4:0]  rd;
        word_t       data;
        logic [31:0] ack_time;
    } exp_t;

    logic      clk;
    logic      rst_n_i;
    logic      wb_cyc_i;
    logic      wb_stb_i;
    logic      wb_we_i;
    inst_t     wb_dat_i;
    logic      wb_ack_o;
    logic      retire_valid_o;
    reg_addr_t retire_rd_o;
    word_t     retire_data_o;

    reg_arr_t    model_regs;
    exp_t        exp_q [$];
    exp_t        head_exp;
    logic [31:0] cycle_cnt = '0;

    rv_alu_top dut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_o       (wb_ack_o),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR: %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic inst_t make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t make_r(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    // ISA level result; returns 1 when the instruction writes a register
    function automatic logic ref_result(input inst_t ins, input reg_arr_t regs,
                                        output logic [4:0] rd, output word_t val);
        logic [2:0] f3;
        logic [4:0] sh;
        logic       known;
        word_t      a;
        word_t      b;
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        known = 1'b1;
        val   = '0;
        if (ins[6:0] == OPC_IMM) begin
            b = {{20{ins[31]}}, ins[31:20]};
        end else if (ins[6:0] == OPC_REG) begin
            if (ins[31:25] != 7'd0 && !(ins[31:25] == F7_SUB_SRA && (f3 == 3'd0 || f3 == 3'd5)))
                known = 1'b0;
        end else begin
            known = 1'b0;
        end
        sh = (ins[6:0] == OPC_IMM) ? ins[24:20] : b[4:0];
        case (f3)
            3'd0: val = (ins[6:0] == OPC_REG && ins[30]) ? a - b : a + b;
            3'd1: val = a << sh;
            3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: val = (a < b) ? 32'd1 : 32'd0;
            3'd4: val = a ^ b;
            3'd5: begin
                val = a >> sh;
                if (ins[30] && a[31]) val = val | ~(32'hffff_ffff >> sh);   // sign fill
            end
            3'd6: val = a | b;
            default: val = a & b;
        endcase
        return known && rd != 5'd0;
    endfunction

    function automatic inst_t random_imm_inst();
        logic [2:0]  f3;
        logic [11:0] imm;
        f3  = 3'($urandom());
        imm = 12'($urandom());
        if (f3 == 3'd1) imm = {7'd0, imm[4:0]};
        else if (f3 == 3'd5) imm = {(imm[11] ? F7_SUB_SRA : 7'd0), imm[4:0]};
        return make_i(imm, 5'($urandom()), f3, 5'($urandom()), OPC_IMM);
    endfunction

    function automatic inst_t random_reg_inst();
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'($urandom());
        f7 = 7'd0;
        if ((f3 == 3'd0 || f3 == 3'd5) && 1'($urandom())) f7 = F7_SUB_SRA;   // sub or sra
        return make_r(f7, 5'($urandom()), 5'($urandom()), f3, 5'($urandom()), OPC_REG);
    endfunction

    // one Wishbone write, model update and expected retire on ack
    task automatic issue(input inst_t instr, input int gap);
        logic [4:0] rd;
        word_t      val;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_dat_i <= instr;
        @(negedge clk);
        while (!wb_ack_o) @(negedge clk);
        if (ref_result(instr, model_regs, rd, val)) begin
            model_regs[rd] = val;
            exp_q.push_back('{rd: rd, data: val, ack_time: cycle_cnt});
        end
        @(posedge clk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(negedge clk);
        check_value("wb_ack_o", {31'd0, wb_ack_o}, 32'd0);   // ack lasts one cycle
        repeat (gap) @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (rst_n_i && retire_valid_o) begin
            if (exp_q.size() == 0) begin
                abort_run("retire pulse seen with no instruction outstanding");
            end else begin
                head_exp = exp_q.pop_front();
                check_value("retire_rd_o", {27'd0, retire_rd_o}, {27'd0, head_exp.rd});
                check_value("retire_data_o", retire_data_o, head_exp.data);
                check_value("retire_valid_o latency", cycle_cnt - head_exp.ack_time,
                            ACK_TO_RETIRE);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the test sequence completed");
    end

    initial begin
        logic [4:0] rd;
        logic [4:0] prev;
        void'($urandom(32'h4edd_3d0b));
        rst_n_i  = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_dat_i = '0;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int i = 1; i < 32; i++) issue(make_i(12'($urandom()), 5'd0, 3'd0, 5'(i), OPC_IMM), 0);

        issue(make_i(12'h800, 5'd0, 3'd0, 5'd31, OPC_IMM), 0);                    // -2048
        issue(make_i({F7_SUB_SRA, 5'd3}, 5'd31, 3'd5, 5'd30, OPC_IMM), 0);        // srai
        issue(make_i(12'hfff, 5'd31, 3'd3, 5'd29, OPC_IMM), 0);                   // sltiu -1
        for (int i = 0; i < N_IMM; i++) issue(random_imm_inst(), 0);

        issue(make_r(F7_SUB_SRA, 5'd2, 5'd1, 3'd0, 5'd27, OPC_REG), 0);           // sub
        issue(make_r(F7_SUB_SRA, 5'd3, 5'd31, 3'd5, 5'd26, OPC_REG), 0);          // sra
        for (int i = 0; i < N_REG; i++) issue(random_reg_inst(), 0);

        prev = 5'd1;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'($urandom_range(31, 1));
            if (i % 2 == 0) begin
                issue(make_i(12'($urandom()), prev, 3'd0, rd, OPC_IMM), 0);
            end else begin
                issue(make_r(7'd0, prev, 5'($urandom()), 3'd4, rd, OPC_REG), 0);
            end
            prev = rd;
        end

        issue(make_i(12'h123, 5'd0, 3'd0, 5'd0, OPC_IMM), 0);                     // x0 targets
        issue(make_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd0, OPC_REG), 0);
        issue(make_i(12'h010, 5'd1, 3'd2, 5'd5, OPC_LOAD), 0);
        issue(make_r(7'd0, 5'd3, 5'd1, 3'd2, 5'd4, OPC_STORE), 0);
        issue(make_r(7'd0, 5'd3, 5'd1, 3'd0, 5'd8, OPC_BRANCH), 0);
        issue({20'habcde, 5'd6, OPC_LUI}, 0);
        issue(make_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd8, OPC_REG), 0);                  // reads x0
        issue(make_i(12'h000, 5'd0, 3'd6, 5'd9, OPC_IMM), 0);

        for (int i = 0; i < N_GAP; i++) begin
            if (1'($urandom())) issue(random_imm_inst(), int'($urandom_range(3, 0)));
            else issue(random_reg_inst(), int'($urandom_range(3, 0)));
        end

        repeat (10) @(posedge clk);   // last retire plus room for a stray one
        if (exp_q.size() != 0) begin
            abort_run("instructions still outstanding at end of run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
